// ==== dv/ooo_stimulus.txt ====
// program words at @00, one per pc/4: nibbles op rd rs1 rs2 then imm16, op 7 ends the program
// expected commits at @40: kind(1) rd(1) data(8) pc(8), kind f ends the list
@00
31000005 // 00 addi r1, r0, 5
32000007 // 04 addi r2, r0, 7
03120000 // 08 add  r3, r1, r2
14310000 // 0c sub  r4, r3, r1
25420000 // 10 xor  r5, r4, r2
30300064 // 14 addi r0, r3, 100
06010000 // 18 add  r6, r0, r1
4042000c // 1c beq  r4, r2, +12 taken
37000001 // 20 addi r7, r0, 1 wrong path
38000002 // 24 addi r8, r0, 2 wrong path
3960ffff // 28 addi r9, r6, -1
40910008 // 2c beq  r9, r1, +8 not taken
0a990000 // 30 add  r10, r9, r9
3aa00003 // 34 addi r10, r10, 3
2ba60000 // 38 xor  r11, r10, r6
40500008 // 3c beq  r5, r0, +8 taken
3c000055 // 40 addi r12, r0, 0x55 wrong path
1cba0000 // 44 sub  r12, r11, r10
70000000 // end of program
@40
110000000500000000
120000000700000004
130000000c00000008
14000000070000000c
150000000000000010
100000007000000014
160000000500000018
10000000000000001c
190000000400000028
10000000000000002c
1a0000000800000030
1a0000000b00000034
1b0000000e00000038
10000000000000003c
1c0000000300000044
f00000000000000000

// ==== dv/tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();

    localparam int ROB_DEPTH = 8;
    localparam int EXEC_LAT  = 2;
    localparam int CLK_NS    = 100;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    inst_t       inst;
    credit_cnt_t credit_ret;
    commit_t     commit;
    logic        redirect_valid;
    xlen_t       redirect_pc;

    logic [71:0] image [128];   // program from 0x00, expected commits from 0x40
    int          prog_len;
    int          credits;
    logic [6:0]  exp_addr;
    int          exp_tag;
    xlen_t       fetch_pc;
    logic [31:0] lcg_state;
    logic        done;

    ooo_core #(.ROB_DEPTH(ROB_DEPTH), .EXEC_LAT(EXEC_LAT)) DUT (
        .clk, .rst_n, .inst_valid, .inst, .credit_ret, .commit,
        .redirect_valid, .redirect_pc
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // program word nibbles are op, rd, rs1, rs2, then a 16-bit imm
    function automatic inst_t decode_word(input logic [71:0] word, input xlen_t pc);
        inst_t i;
        i.op  = word[30:28];
        i.rd  = word[27:24];
        i.rs1 = word[23:20];
        i.rs2 = word[19:16];
        i.imm = word[15:0];
        i.pc  = pc;
        return i;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    // fetch model, credit counter and commit checker share one clocked process
    always @(posedge clk) begin
        logic [71:0] word;
        logic [71:0] exp_word;
        if (!rst_n) begin
            inst_valid <= 1'b0;
            inst       <= '0;
            credits   = ROB_DEPTH;
            fetch_pc  = '0;
            exp_addr  = 7'h40;
            exp_tag   = 0;
            lcg_state = 32'hecacd825;
            done      = 1'b0;
        end else begin
            // an instruction shown during a redirect is dropped and keeps its credit
            if (inst_valid && !redirect_valid) begin
                credits  = credits - 1;
                fetch_pc = fetch_pc + 32'd4;
            end
            credits = credits + int'(credit_ret);
            if (credits < 0 || credits > ROB_DEPTH)
                abort_run($sformatf("credit count %0d left the range 0 to %0d",
                                    credits, ROB_DEPTH));
            if (redirect_valid) begin
                word = image[commit.pc[8:2]];
                check("commit.valid", 32'(commit.valid), 32'd1);
                check("branch op", 32'(word[30:28]), 32'(OP_BEQ));
                check("redirect_pc", redirect_pc, commit.pc + {{16{word[15]}}, word[15:0]});
                fetch_pc = redirect_pc;
            end
            if (commit.valid) begin
                exp_word = image[exp_addr];
                if (exp_word[71:68] != 4'h1)
                    abort_run("an instruction committed after the end of the expected list");
                check("commit.rd", 32'(commit.rd), 32'(exp_word[67:64]));
                check("commit.data", commit.data, exp_word[63:32]);
                check("commit.pc", commit.pc, exp_word[31:0]);
                // tags count up from 0 after reset and after every flush
                check("commit.tag", 32'(commit.tag), 32'(exp_tag));
                exp_tag  = redirect_valid ? 0 : (exp_tag + 1) % ROB_DEPTH;
                exp_addr = exp_addr + 7'd1;
                if (image[exp_addr][71:68] == 4'hf) begin
                    check("credits", 32'(credits), 32'(ROB_DEPTH));
                    done = 1'b1;
                end
            end
            lcg_state = lcg_next(lcg_state);
            if (fetch_pc[31:2] < 30'(prog_len) && credits > 0 && !done
                    && lcg_state[31:30] != 2'b00) begin
                inst_valid <= 1'b1;
                inst       <= decode_word(image[fetch_pc[8:2]], fetch_pc);
            end else begin
                inst_valid <= 1'b0;   // idle when throttled, out of credit or past the end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n      <= 1'b0;
        inst_valid <= 1'b0;
        inst       <= '0;
        $readmemh("dv/ooo_stimulus.txt", image);
        prog_len = 0;
        while (prog_len < 64 && image[7'(prog_len)][31:28] != 4'h7)
            prog_len++;
        if (prog_len == 0)
            abort_run("program image is empty or missing");
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait (done);
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    // watchdog scaled to program length
    initial begin
        #1;
        #(CLK_NS * (200 * prog_len + 10));
        abort_run("timeout: the commit stream did not complete in time");
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_ooo_core -f sim.f -o sim_ooo \
    && ./obj_dir/sim_ooo \
    || exit 1

// ==== sim.f ====
src/ooo_pkg.sv
src/rename_regfile.sv
src/issue_queue.sv
src/exec_pipe.sv
src/reorder_buffer.sv
src/ooo_core.sv
dv/tb_ooo_core.sv

// ==== src/exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_pipe import ooo_pkg::*; #(
    parameter int EXEC_LAT = 2
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   issue_valid,
    input  issue_t issue_inst,
    input  logic   flush,
    output cdb_t   cdb
);

    cdb_t                result;
    cdb_t                stage [EXEC_LAT];
    logic [EXEC_LAT-1:0] stage_valid;
    xlen_t               imm_ext;

    always_comb begin
        imm_ext           = {{16{issue_inst.inst.imm[15]}}, issue_inst.inst.imm};
        result.valid      = issue_valid;
        result.tag        = issue_inst.tag;
        result.mispredict = 1'b0;
        result.target     = issue_inst.inst.pc + imm_ext;
        case (issue_inst.inst.op)
            OP_ADD:  result.data = issue_inst.src1 + issue_inst.src2;
            OP_SUB:  result.data = issue_inst.src1 - issue_inst.src2;
            OP_XOR:  result.data = issue_inst.src1 ^ issue_inst.src2;
            OP_ADDI: result.data = issue_inst.src1 + imm_ext;
            OP_BEQ: begin
                result.data       = '0;
                // predicted not-taken, so taken means mispredict
                result.mispredict = (issue_inst.src1 == issue_inst.src2);
            end
            default: result.data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue_valid;
            for (int i = 1; i < EXEC_LAT; i++)
                stage_valid[i] <= stage_valid[i-1];
        end
    end

    always_ff @(posedge clk) begin
        stage[0] <= result;
        for (int i = 1; i < EXEC_LAT; i++)
            stage[i] <= stage[i-1];
    end

    always_comb begin
        cdb       = stage[EXEC_LAT-1];
        cdb.valid = stage_valid[EXEC_LAT-1];
    end

endmodule

`default_nettype wire

// ==== src/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alloc_valid,
    input  inst_t    alloc_inst,
    input  rob_tag_t alloc_tag,
    input  logic     src1_busy,
    input  rob_tag_t src1_rename_tag,
    input  xlen_t    src1_value,
    input  logic     src2_busy,
    input  rob_tag_t src2_rename_tag,
    input  xlen_t    src2_value,
    input  xlen_t    src1_rob_data,
    input  logic     src1_rob_ready,
    input  xlen_t    src2_rob_data,
    input  logic     src2_rob_ready,
    output rob_tag_t src1_tag,
    output rob_tag_t src2_tag,
    input  cdb_t     cdb,
    input  logic     flush,
    output logic     issue_valid,
    output issue_t   issue_inst
);

    localparam int PW = $clog2(ROB_DEPTH);

    typedef struct packed {
        inst_t    inst;
        rob_tag_t tag;
        operand_t src1;
        operand_t src2;
    } iq_entry_t;

    iq_entry_t     queue [ROB_DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [PW:0]   count;
    operand_t      new_src1;
    operand_t      new_src2;

    // regfile first, then the live cdb, then a finished rob entry
    function automatic operand_t resolve(input logic busy, input rob_tag_t tag,
                                         input xlen_t value, input xlen_t rob_data,
                                         input logic rob_ready, input cdb_t bus);
        operand_t opnd;
        opnd.tag   = tag;
        opnd.ready = 1'b1;
        opnd.value = '0;
        if (!busy)
            opnd.value = value;
        else if (bus.valid && bus.tag == tag)
            opnd.value = bus.data;
        else if (rob_ready)
            opnd.value = rob_data;
        else
            opnd.ready = 1'b0;   // wait for the broadcast
        return opnd;
    endfunction

    assign src1_tag = src1_rename_tag;
    assign src2_tag = src2_rename_tag;

    always_comb begin
        new_src1 = resolve(src1_busy, src1_rename_tag, src1_value,
                           src1_rob_data, src1_rob_ready, cdb);
        new_src2 = resolve(src2_busy, src2_rename_tag, src2_value,
                           src2_rob_data, src2_rob_ready, cdb);
        if (alloc_inst.op == OP_ADDI)
            new_src2.ready = 1'b1;   // imm form has no rs2
    end

    assign issue_valid = (count != '0) && queue[head].src1.ready && queue[head].src2.ready;

    always_comb begin
        issue_inst.inst = queue[head].inst;
        issue_inst.tag  = queue[head].tag;
        issue_inst.src1 = queue[head].src1.value;
        issue_inst.src2 = queue[head].src2.value;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (issue_valid)
                head <= head + 1'b1;
            if (alloc_valid)
                tail <= tail + 1'b1;
            count <= count + (PW+1)'(alloc_valid) - (PW+1)'(issue_valid);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (cdb.valid && !queue[i].src1.ready && queue[i].src1.tag == cdb.tag) begin
                queue[i].src1.ready <= 1'b1;
                queue[i].src1.value <= cdb.data;
            end
            if (cdb.valid && !queue[i].src2.ready && queue[i].src2.tag == cdb.tag) begin
                queue[i].src2.ready <= 1'b1;
                queue[i].src2.value <= cdb.data;
            end
        end
        if (alloc_valid)
            queue[tail] <= '{inst: alloc_inst, tag: alloc_tag, src1: new_src1, src2: new_src2};
    end

endmodule

`default_nettype wire

// ==== src/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int EXEC_LAT  = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  inst_t       inst,
    output credit_cnt_t credit_ret,
    output commit_t     commit,
    output logic        redirect_valid,
    output xlen_t       redirect_pc
);

    logic     alloc_valid;
    rob_tag_t alloc_tag;
    logic     flush;
    cdb_t     cdb;
    logic     issue_valid;
    issue_t   issue_inst;
    logic     src1_busy;
    logic     src2_busy;
    rob_tag_t src1_rename_tag;
    rob_tag_t src2_rename_tag;
    xlen_t    src1_value;
    xlen_t    src2_value;
    rob_tag_t src1_tag;
    rob_tag_t src2_tag;
    xlen_t    src1_rob_data;
    xlen_t    src2_rob_data;
    logic     src1_rob_ready;
    logic     src2_rob_ready;

    assign alloc_valid    = inst_valid & ~flush;   // wrong-path fetch in the redirect cycle
    assign redirect_valid = flush;

    rename_regfile u_rename (
        .clk, .rst_n, .alloc_valid, .alloc_inst(inst), .alloc_tag,
        .src1_busy, .src1_tag(src1_rename_tag), .src1_value,
        .src2_busy, .src2_tag(src2_rename_tag), .src2_value,
        .commit, .flush
    );

    issue_queue #(.ROB_DEPTH(ROB_DEPTH)) u_iq (
        .clk, .rst_n, .alloc_valid, .alloc_inst(inst), .alloc_tag,
        .src1_busy, .src1_rename_tag, .src1_value,
        .src2_busy, .src2_rename_tag, .src2_value,
        .src1_rob_data, .src1_rob_ready, .src2_rob_data, .src2_rob_ready,
        .src1_tag, .src2_tag, .cdb, .flush, .issue_valid, .issue_inst
    );

    exec_pipe #(.EXEC_LAT(EXEC_LAT)) u_exec (
        .clk, .rst_n, .issue_valid, .issue_inst, .flush, .cdb
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk, .rst_n, .alloc_valid, .alloc_inst(inst), .alloc_tag, .cdb,
        .src1_tag, .src2_tag,
        .src1_data(src1_rob_data), .src1_ready(src1_rob_ready),
        .src2_data(src2_rob_data), .src2_ready(src2_rob_ready),
        .commit, .flush, .redirect_pc, .credit_ret
    );

endmodule

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [3:0]  reg_addr_t;   // 16 registers, r0 reads zero
    typedef logic [3:0]  rob_tag_t;    // covers ROB_DEPTH up to 16
    typedef logic [4:0]  credit_cnt_t;
    typedef logic [2:0]  op_t;

    localparam op_t OP_ADD  = 3'd0;
    localparam op_t OP_SUB  = 3'd1;
    localparam op_t OP_XOR  = 3'd2;
    localparam op_t OP_ADDI = 3'd3;
    localparam op_t OP_BEQ  = 3'd4;

    typedef struct packed {
        op_t         op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [15:0] imm;
        xlen_t       pc;
    } inst_t;

    // one source operand waiting in the issue queue
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        xlen_t    value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    data;
        logic     mispredict;
        xlen_t    target;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;    // retiring rob entry, used to release the rename table
        reg_addr_t rd;
        xlen_t     data;
        xlen_t     pc;
    } commit_t;

    typedef struct packed {
        inst_t    inst;
        rob_tag_t tag;
        xlen_t    src1;
        xlen_t    src2;
    } issue_t;

endpackage

`default_nettype wire

// ==== src/rename_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_regfile import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alloc_valid,
    input  inst_t    alloc_inst,
    input  rob_tag_t alloc_tag,
    output logic     src1_busy,
    output rob_tag_t src1_tag,
    output xlen_t    src1_value,
    output logic     src2_busy,
    output rob_tag_t src2_tag,
    output xlen_t    src2_value,
    input  commit_t  commit,
    input  logic     flush
);

    xlen_t       regs [16];
    rob_tag_t    tags [16];
    logic [15:0] busy;
    logic        renames;

    // branches and r0 never get a rename
    assign renames = alloc_valid && (alloc_inst.op != OP_BEQ) && (alloc_inst.rd != '0);

    always_comb begin
        src1_busy  = busy[alloc_inst.rs1];
        src1_tag   = tags[alloc_inst.rs1];
        src1_value = regs[alloc_inst.rs1];
        if (commit.valid && commit.rd == alloc_inst.rs1 && alloc_inst.rs1 != '0)
            src1_value = commit.data;   // same-cycle writeback bypass
        src2_busy  = busy[alloc_inst.rs2];
        src2_tag   = tags[alloc_inst.rs2];
        src2_value = regs[alloc_inst.rs2];
        if (commit.valid && commit.rd == alloc_inst.rs2 && alloc_inst.rs2 != '0)
            src2_value = commit.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else begin
            if (commit.valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.data;
                // a younger writer may own the register by now
                if (tags[commit.rd] == commit.tag)
                    busy[commit.rd] <= 1'b0;
            end
            if (flush)
                busy <= '0;
            else if (renames)
                busy[alloc_inst.rd] <= 1'b1;   // new rename wins over a retiring one
        end
    end

    always_ff @(posedge clk) begin
        if (renames)
            tags[alloc_inst.rd] <= alloc_tag;
    end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        alloc_valid,
    input  inst_t       alloc_inst,
    output rob_tag_t    alloc_tag,
    input  cdb_t        cdb,
    input  rob_tag_t    src1_tag,
    input  rob_tag_t    src2_tag,
    output xlen_t       src1_data,
    output logic        src1_ready,
    output xlen_t       src2_data,
    output logic        src2_ready,
    output commit_t     commit,
    output logic        flush,
    output xlen_t       redirect_pc,
    output credit_cnt_t credit_ret
);

    localparam int PW = $clog2(ROB_DEPTH);

    typedef struct packed {
        logic      mispredict;
        reg_addr_t rd;
        xlen_t     data;
        xlen_t     pc;
        xlen_t     target;
    } rob_entry_t;

    rob_entry_t           entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_ready;
    logic [PW-1:0]        head;
    logic [PW-1:0]        tail;
    logic [PW:0]          count;
    logic                 retire;
    logic [PW-1:0]        cdb_idx;
    logic [PW-1:0]        s1_idx;
    logic [PW-1:0]        s2_idx;

    assign alloc_tag = rob_tag_t'(tail);
    assign cdb_idx   = cdb.tag[PW-1:0];
    assign s1_idx    = src1_tag[PW-1:0];
    assign s2_idx    = src2_tag[PW-1:0];

    // operand lookup for the issue queue
    assign src1_data  = entries[s1_idx].data;
    assign src1_ready = ent_valid[s1_idx] & ent_ready[s1_idx];
    assign src2_data  = entries[s2_idx].data;
    assign src2_ready = ent_valid[s2_idx] & ent_ready[s2_idx];

    assign retire      = ent_valid[head] & ent_ready[head];
    assign flush       = retire & entries[head].mispredict;
    assign redirect_pc = entries[head].target;

    always_comb begin
        commit.valid = retire;
        commit.tag   = rob_tag_t'(head);
        commit.rd    = entries[head].rd;
        commit.data  = entries[head].data;
        commit.pc    = entries[head].pc;
    end

    always_comb begin
        if (flush)
            credit_ret = credit_cnt_t'(count);   // every occupied slot comes back
        else if (retire)
            credit_ret = credit_cnt_t'(1);
        else
            credit_ret = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_ready <= '0;
        end else begin
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (alloc_valid) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (cdb.valid)
                ent_ready[cdb_idx] <= 1'b1;
            count <= count + (PW+1)'(alloc_valid) - (PW+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            // branches retire with rd 0
            entries[tail].rd <= (alloc_inst.op == OP_BEQ) ? '0 : alloc_inst.rd;
            entries[tail].pc <= alloc_inst.pc;
        end
        if (cdb.valid) begin
            entries[cdb_idx].data       <= cdb.data;
            entries[cdb_idx].mispredict <= cdb.mispredict;
            entries[cdb_idx].target     <= cdb.target;
        end
    end

endmodule

`default_nettype wire
